//--- Bender.yml
package:
  name: exec_core

sources:
  - logic/exec_pkg.sv
  - logic/exec_ctrl_if.sv
  - logic/alu_control.sv
  - logic/exec_unit.sv
  - logic/shift_timer.sv
  - logic/reg_file.sv
  - logic/exec_fsm.sv
  - logic/exec_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/exec_tb.sv

//--- bench/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;
  import exec_pkg::*;

  // Instruction budget times the longest shift latency, with margin
  localparam int MAX_CYCLES = 60 * 40;
  localparam int HALT_WAIT  = 40;

  logic              clk;
  logic              arst_n;
  logic              instr_valid;
  logic [31:0]       instr;
  logic              ready;
  logic              done;
  logic              wb_en;
  logic              halted;
  logic [REG_AW-1:0] wb_addr;
  logic [DATA_W-1:0] wb_data;

  logic [31:0] model_regs [32];
  logic [31:0] rng = 32'hb9054425;
  string       test_name;
  logic        exp_en;
  logic [4:0]  exp_addr;
  logic [31:0] exp_data;
  int          exp_lat;
  logic        exp_halt;
  logic        pending;
  int          lat;
  int          cycles;
  int          retired;
  int          errors;

  tb_clock u_clock (.clk(clk), .arst_n(arst_n));

  exec_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ready       (ready),
    .done        (done),
    .wb_en       (wb_en),
    .halted      (halted),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] itype_result(input logic [5:0] op, input logic [31:0] a,
                                               input logic [15:0] imm);
    logic [31:0] sx;
    logic [31:0] zx;
    sx = {{16{imm[15]}}, imm};
    zx = {16'h0000, imm};
    case (op)
      OP_ADDI: return a + sx;
      OP_ANDI: return a & zx;
      OP_ORI:  return a | zx;
      OP_XORI: return a ^ zx;
      OP_LUI:  return {imm, 16'h0000};
      default: return ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] rtype_result(input logic [5:0] funct, input logic [31:0] a,
                                               input logic [31:0] b, input logic [4:0] shamt);
    case (funct)
      F_ADDU:  return a + b;
      F_SUBU:  return a - b;
      F_AND:   return a & b;
      F_OR:    return a | b;
      F_XOR:   return a ^ b;
      F_NOR:   return ~(a | b);
      F_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F_SLL:   return b << shamt;
      F_SRL:   return b >> shamt;
      F_SRA:   return $signed(b) >>> shamt;
      F_SLLV:  return b << a[4:0];
      F_SRLV:  return b >> a[4:0];
      default: return $signed(b) >>> a[4:0];
    endcase
  endfunction

  // Extra EXEC cycles spent shifting
  function automatic int shift_amount(input logic [5:0] funct, input logic [31:0] a,
                                      input logic [4:0] shamt);
    case (funct)
      F_SLL, F_SRL, F_SRA:    return shamt;
      F_SLLV, F_SRLV, F_SRAV: return a[4:0];
      default:                return 0;
    endcase
  endfunction

  function automatic logic [5:0] pick_iop(input int k);
    case (k % 6)
      0:       return OP_ADDI;
      1:       return OP_ANDI;
      2:       return OP_ORI;
      3:       return OP_XORI;
      4:       return OP_LUI;
      default: return OP_SLTI;
    endcase
  endfunction

  function automatic logic [5:0] pick_funct(input int k);
    case (k % 7)
      0:       return F_ADDU;
      1:       return F_SUBU;
      2:       return F_AND;
      3:       return F_OR;
      4:       return F_XOR;
      5:       return F_NOR;
      default: return F_SLT;
    endcase
  endfunction

  function automatic logic [5:0] pick_shift(input int k);
    case (k % 6)
      0:       return F_SLL;
      1:       return F_SRL;
      2:       return F_SRA;
      3:       return F_SLLV;
      4:       return F_SRLV;
      default: return F_SRAV;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic send_instr(input string name, input logic [31:0] word, input logic en,
                            input logic [4:0] addr, input logic [31:0] data, input int latency,
                            input logic halt);
    @(posedge clk);
    test_name   <= name;
    instr_valid <= 1'b1;
    instr       <= word;
    exp_en      <= en;
    exp_addr    <= addr;
    exp_data    <= data;
    exp_lat     <= latency;
    exp_halt    <= halt;
    @(posedge clk);
    instr_valid <= 1'b0;
    do begin
      @(posedge clk);
    end while (!done);
  endtask

  task automatic run_i(input string name, input logic [5:0] op, input logic [4:0] rs,
                       input logic [4:0] rt, input logic [15:0] imm);
    logic [31:0] res;
    res = itype_result(op, model_regs[rs], imm);
    send_instr(name, {op, rs, rt, imm}, rt != 5'd0, rt, res, 4, 1'b0);
    if (rt != 5'd0) begin
      model_regs[rt] = res;
    end
  endtask

  task automatic run_r(input string name, input logic [5:0] funct, input logic [4:0] rs,
                       input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
    logic [31:0] res;
    int          amt;
    res = rtype_result(funct, model_regs[rs], model_regs[rt], shamt);
    amt = shift_amount(funct, model_regs[rs], shamt);
    send_instr(name, {OP_RTYPE, rs, rt, rd, shamt, funct}, rd != 5'd0, rd, res, 4 + amt, 1'b0);
    if (rd != 5'd0) begin
      model_regs[rd] = res;
    end
  endtask

  // Retires with done only
  task automatic run_nop(input string name, input logic [31:0] word);
    send_instr(name, word, 1'b0, 5'd0, 32'h0, 4, 1'b0);
  endtask

  initial begin
    logic [4:0] ra;
    logic [4:0] rb;
    instr_valid <= 1'b0;
    instr       <= '0;
    exp_halt    <= 1'b0;
    exp_en      <= 1'b0;
    test_name   <= "reset";
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    do begin
      @(posedge clk);
    end while (!arst_n);

    run_i("addi_neg", OP_ADDI, 5'd0, 5'd1, 16'hfff0);
    run_i("lui_sign", OP_LUI, 5'd0, 5'd2, 16'h8000);
    // First loads from r0, later ones chain earlier results
    for (int k = 0; k < 10; k++) begin
      rng = xorshift32(rng);
      ra  = (k < 4) ? 5'd0 : 5'(rng[31:16] % (k + 2));
      run_i($sformatf("itype_%0d", k), pick_iop(k), ra, 5'(k + 3), rng[15:0]);
    end

    for (int k = 0; k < 14; k++) begin
      rng = xorshift32(rng);
      ra  = 5'(rng[4:0] % 12) + 5'd1;
      rb  = 5'(rng[12:8] % 12) + 5'd1;
      run_r($sformatf("rtype_%0d", k), pick_funct(k), ra, rb, 5'(13 + k % 8), 5'd0);
    end
    run_r("addu_r0", F_ADDU, 5'd1, 5'd2, 5'd0, 5'd0);

    for (int k = 0; k < 12; k++) begin
      rng = xorshift32(rng);
      ra  = 5'(rng[4:0] % 20) + 5'd1;
      rb  = 5'(rng[12:8] % 20) + 5'd1;
      run_r($sformatf("shift_%0d", k), pick_shift(k), ra, rb, 5'(21 + k % 6), rng[20:16]);
    end
    run_r("sra_31", F_SRA, 5'd0, 5'd2, 5'd27, 5'd31);

    run_nop("lw", {OP_LW, 5'd1, 5'd3, 16'h0010});
    run_nop("sw", {OP_SW, 5'd1, 5'd4, 16'h0020});
    run_nop("beq", {OP_BEQ, 5'd1, 5'd5, 16'h0004});
    run_nop("nop", {OP_NOP, 5'd0, 5'd7, 16'h1234});
    run_nop("bad_funct", {OP_RTYPE, 5'd1, 5'd2, 5'd6, 5'd0, 6'b001000});
    // Copies through r0 show the targets kept their values
    for (int k = 3; k < 8; k++) begin
      run_r($sformatf("read_r%0d", k), F_OR, 5'(k), 5'd0, 5'd29, 5'd0);
    end

    send_instr("halt", {OP_HALT, 26'h0}, 1'b0, 5'd0, 32'h0, 4, 1'b1);
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= {OP_ADDI, 5'd0, 5'd1, 16'h0001};
    repeat (HALT_WAIT) @(posedge clk);
    instr_valid <= 1'b0;
    repeat (2) @(posedge clk);

    $display("%0d instructions retired, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Latency tracking and watchdog
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
      lat     <= 0;
    end else if (instr_valid && ready) begin
      pending <= 1'b1;
      lat     <= 1;
    end else if (done) begin
      pending <= 1'b0;
      retired <= retired + 1;
    end else if (pending) begin
      lat <= lat + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped after %0d cycles with the core stuck", cycles);
      $display("%0d instructions retired, %0d errors", retired, errors);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////
  a_reset_state: assert property (
    @(posedge clk) $rose(arst_n) |-> ready && !done && !wb_en && !halted
  ) else begin
    errors++;
    $display("Outputs not at their idle values after reset");
  end

  a_wb_en: assert property (@(posedge clk) disable iff (!arst_n) done |-> wb_en == exp_en)
    else begin
      errors++;
      $display("FAILED %s wb_en expected %0b actual %0b", test_name, exp_en, $sampled(wb_en));
    end

  a_wb_addr: assert property (
    @(posedge clk) disable iff (!arst_n) done && exp_en |-> wb_addr == exp_addr
  ) else begin
    errors++;
    $display("FAILED %s wb_addr expected %0d actual %0d", test_name, exp_addr,
             $sampled(wb_addr));
  end

  a_wb_data: assert property (
    @(posedge clk) disable iff (!arst_n) done && exp_en |-> wb_data == exp_data
  ) else begin
    errors++;
    $display("FAILED %s wb_data expected %h actual %h", test_name, exp_data, $sampled(wb_data));
  end

  a_latency: assert property (@(posedge clk) disable iff (!arst_n) done |-> lat == exp_lat)
    else begin
      errors++;
      $display("FAILED %s latency expected %0d actual %0d", test_name, exp_lat, $sampled(lat));
    end

  a_done_owner: assert property (@(posedge clk) disable iff (!arst_n) done |-> pending)
    else begin
      errors++;
      $display("Done pulsed with no instruction in flight");
    end

  a_no_stray_write: assert property (@(posedge clk) disable iff (!arst_n) !done |-> !wb_en)
    else begin
      errors++;
      $display("Register write outside a done cycle");
    end

  a_busy: assert property (@(posedge clk) disable iff (!arst_n) pending |-> !ready)
    else begin
      errors++;
      $display("Ready went high while %s was still executing", test_name);
    end

  a_halt_enter: assert property (
    @(posedge clk) disable iff (!arst_n) done && exp_halt |=> halted
  ) else begin
    errors++;
    $display("Core did not halt after the HALT instruction");
  end

  a_halt_hold: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted && !ready)
    else begin
      errors++;
      $display("Core left the halted state or raised ready before reset");
    end

  a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n) halted |-> !done)
    else begin
      errors++;
      $display("Done pulsed while the core was halted");
    end

  a_no_early_halt: assert property (@(posedge clk) disable iff (!arst_n) !exp_halt |-> !halted)
    else begin
      errors++;
      $display("Halted went high before any HALT instruction");
    end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic arst_n
);
  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset released on a rising edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

//--- list.f
logic/exec_pkg.sv
logic/exec_ctrl_if.sv
logic/alu_control.sv
logic/exec_unit.sv
logic/shift_timer.sv
logic/reg_file.sv
logic/exec_fsm.sv
logic/exec_top.sv
bench/tb_clock.sv
bench/exec_tb.sv

//--- logic/alu_control.sv
`timescale 1ns/1ps

module alu_control (
  input  exec_pkg::aluop_t    aluop,
  input  exec_pkg::instr_t    instr,
  output exec_pkg::alu_code_t code
);
  import exec_pkg::*;

  always_comb begin
    case (aluop)
      // Loads, stores and BEQ do nothing here
      MEM, BRANCH: begin
        code = NONE;
      end
      RTYPE: begin
        case (instr.r.funct)
          F_SLL:   code = SLL;
          F_SRL:   code = SRL;
          F_SRA:   code = SRA;
          F_SLLV:  code = SLLV;
          F_SRLV:  code = SRLV;
          F_SRAV:  code = SRAV;
          F_ADDU:  code = ADD;
          F_SUBU:  code = SUB;
          F_OR:    code = OR;
          F_XOR:   code = XOR;
          F_AND:   code = AND;
          F_NOR:   code = NOR;
          F_SLT:   code = SLT;
          default: code = NONE;
        endcase
      end
      ITYPE: begin
        case (instr.i.opcode)
          OP_ADDI: code = ADD;
          OP_ANDI: code = AND;
          OP_ORI:  code = OR;
          OP_XORI: code = XOR;
          OP_LUI:  code = LUI;
          OP_SLTI: code = SLT;
          // NOP and HALT retire without a result
          OP_NOP:  code = NONE;
          OP_HALT: code = NONE;
          default: code = NONE;
        endcase
      end
      default: begin
        code = NONE;
      end
    endcase
  end

endmodule

//--- logic/exec_ctrl_if.sv
`timescale 1ns/1ps

interface exec_ctrl_if (
  input logic clk
);
  import exec_pkg::*;

  logic               start;
  alu_code_t          code;
  logic [SHAMT_W-1:0] amount;
  logic               step;
  logic               finished;

  modport fsm (
    output start,
    output code,
    input  finished
  );

  modport unit (
    input  start,
    input  code,
    input  step,
    output amount
  );

  modport timer (
    input  start,
    input  amount,
    output step,
    output finished
  );

  // Start never lasts longer than one cycle
  a_start_pulse: assert property (@(posedge clk) start |=> !start);

endinterface

//--- logic/exec_fsm.sv
`timescale 1ns/1ps

module exec_fsm (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        instr_valid,
  input  exec_pkg::instr_t            instr_in,
  exec_ctrl_if.fsm                    ctrl,
  input  exec_pkg::alu_code_t         code,
  output exec_pkg::instr_t            instr,
  output exec_pkg::aluop_t            aluop,
  output logic [exec_pkg::REG_AW-1:0] w_addr,
  output logic                        w_en,
  output logic                        ready,
  output logic                        done,
  output logic                        halted
);
  import exec_pkg::*;

  state_t state;
  state_t state_nxt;
  logic   is_halt;

  // Instruction register, loaded on accept
  always_ff @(posedge clk) begin
    if (ready && instr_valid) begin
      instr <= instr_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (instr.r.opcode)
      OP_RTYPE:     aluop = RTYPE;
      OP_LW, OP_SW: aluop = MEM;
      OP_BEQ:       aluop = BRANCH;
      default:      aluop = ITYPE;
    endcase
  end

  assign is_halt   = (instr.i.opcode == OP_HALT);
  assign w_addr    = (aluop == RTYPE) ? instr.r.rd : instr.i.rt;
  assign ctrl.code = code;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (instr_valid) state_nxt = DECODE;
      DECODE:  state_nxt = EXEC;
      EXEC:    if (ctrl.finished) state_nxt = WBACK;
      WBACK:   state_nxt = is_halt ? HALTED : IDLE;
      HALTED:  state_nxt = HALTED;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      ctrl.start <= 1'b0;
    end else begin
      state      <= state_nxt;
      // pulse on the way into EXEC
      ctrl.start <= (state == DECODE);
    end
  end

  assign ready  = (state == IDLE);
  assign done   = (state == WBACK);
  assign halted = (state == HALTED);
  assign w_en   = done && (code != NONE) && (w_addr != '0);

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!arst_n) done |=> !done
  );

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int DATA_W  = 32;
  localparam int REG_AW  = 5;
  localparam int SHAMT_W = 5;

  // R-type funct field
  localparam logic [5:0] F_SLL  = 6'b000000;
  localparam logic [5:0] F_SRL  = 6'b000010;
  localparam logic [5:0] F_SRA  = 6'b000011;
  localparam logic [5:0] F_SLLV = 6'b000100;
  localparam logic [5:0] F_SRLV = 6'b000110;
  localparam logic [5:0] F_SRAV = 6'b000111;
  localparam logic [5:0] F_ADDU = 6'b100001;
  localparam logic [5:0] F_SUBU = 6'b100011;
  localparam logic [5:0] F_OR   = 6'b100101;
  localparam logic [5:0] F_XOR  = 6'b100110;
  localparam logic [5:0] F_AND  = 6'b100100;
  localparam logic [5:0] F_NOR  = 6'b100111;
  localparam logic [5:0] F_SLT  = 6'b101010;

  // Opcodes
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_ADDI  = 6'b001000;
  localparam logic [5:0] OP_ANDI  = 6'b001100;
  localparam logic [5:0] OP_ORI   = 6'b001101;
  localparam logic [5:0] OP_XORI  = 6'b001110;
  localparam logic [5:0] OP_LUI   = 6'b001111;
  localparam logic [5:0] OP_SLTI  = 6'b001010;
  localparam logic [5:0] OP_NOP   = 6'b111000;
  localparam logic [5:0] OP_HALT  = 6'b111111;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, seen as R or I format
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [5:0]         opcode;
    logic [REG_AW-1:0]  rs;
    logic [REG_AW-1:0]  rt;
    logic [REG_AW-1:0]  rd;
    logic [SHAMT_W-1:0] shamt;
    logic [5:0]         funct;
  } instr_r_t;

  typedef struct packed {
    logic [5:0]        opcode;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [15:0]       imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

  typedef enum logic [1:0] {
    MEM    = 2'd0,
    BRANCH = 2'd1,
    RTYPE  = 2'd2,
    ITYPE  = 2'd3
  } aluop_t;

  // Code 14 is unused, 15 means no operation
  typedef enum logic [3:0] {
    SLL  = 4'd0,
    SRL  = 4'd1,
    SRA  = 4'd2,
    SLLV = 4'd3,
    SRLV = 4'd4,
    SRAV = 4'd5,
    ADD  = 4'd6,
    SUB  = 4'd7,
    OR   = 4'd8,
    XOR  = 4'd9,
    AND  = 4'd10,
    NOR  = 4'd11,
    SLT  = 4'd12,
    LUI  = 4'd13,
    NONE = 4'd15
  } alu_code_t;

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    EXEC,
    WBACK,
    HALTED
  } state_t;

endpackage

//--- logic/exec_top.sv
`timescale 1ns/1ps

module exec_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        instr_valid,
  input  logic [exec_pkg::DATA_W-1:0] instr,
  output logic                        ready,
  output logic                        done,
  output logic                        wb_en,
  output logic                        halted,
  output logic [exec_pkg::REG_AW-1:0] wb_addr,
  output logic [exec_pkg::DATA_W-1:0] wb_data
);
  import exec_pkg::*;

  instr_t            instr_q;
  aluop_t            aluop;
  alu_code_t         code;
  logic [DATA_W-1:0] rs_data;
  logic [DATA_W-1:0] rt_data;

  exec_ctrl_if ctrl_if (.clk(clk));

  exec_fsm u_fsm (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr_in    (instr),
    .ctrl        (ctrl_if.fsm),
    .code        (code),
    .instr       (instr_q),
    .aluop       (aluop),
    .w_addr      (wb_addr),
    .w_en        (wb_en),
    .ready       (ready),
    .done        (done),
    .halted      (halted)
  );

  alu_control u_alu_control (
    .aluop (aluop),
    .instr (instr_q),
    .code  (code)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .arst_n  (arst_n),
    .ra_addr (instr_q.r.rs),
    .rb_addr (instr_q.r.rt),
    .w_addr  (wb_addr),
    .w_en    (wb_en),
    .w_data  (wb_data),
    .ra_data (rs_data),
    .rb_data (rt_data)
  );

  exec_unit u_exec_unit (
    .clk     (clk),
    .arst_n  (arst_n),
    .ctrl    (ctrl_if.unit),
    .instr   (instr_q),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .result  (wb_data)
  );

  shift_timer u_shift_timer (
    .clk    (clk),
    .arst_n (arst_n),
    .ctrl   (ctrl_if.timer)
  );

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                        clk,
  input  logic                        arst_n,
  exec_ctrl_if.unit                   ctrl,
  input  exec_pkg::instr_t            instr,
  input  logic [exec_pkg::DATA_W-1:0] rs_data,
  input  logic [exec_pkg::DATA_W-1:0] rt_data,
  output logic [exec_pkg::DATA_W-1:0] result
);
  import exec_pkg::*;

  logic              is_itype;
  logic              is_shift;
  logic              is_var_shift;
  logic              slt_bit;
  logic [DATA_W-1:0] imm_sext;
  logic [DATA_W-1:0] imm_zext;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] alu_out;

  //////////////////////////////////////////////////////////////////////
  // Operand forming
  //////////////////////////////////////////////////////////////////////
  assign is_itype     = (instr.i.opcode != OP_RTYPE);
  assign is_shift     = ctrl.code inside {SLL, SRL, SRA, SLLV, SRLV, SRAV};
  assign is_var_shift = ctrl.code inside {SLLV, SRLV, SRAV};

  assign imm_sext = {{(DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
  assign imm_zext = {{(DATA_W-16){1'b0}}, instr.i.imm};

  // Logic ops take the immediate unsigned, ADDI and SLTI signed
  assign op_b = !is_itype                       ? rt_data  :
                (ctrl.code inside {AND, OR, XOR}) ? imm_zext : imm_sext;

  // Shift count for the timer, zero for anything else
  assign ctrl.amount = !is_shift     ? '0 :
                       is_var_shift ? rs_data[SHAMT_W-1:0] : instr.r.shamt;

  assign slt_bit = ($signed(rs_data) < $signed(op_b));

  always_comb begin
    case (ctrl.code)
      ADD:     alu_out = rs_data + op_b;
      SUB:     alu_out = rs_data - op_b;
      OR:      alu_out = rs_data | op_b;
      XOR:     alu_out = rs_data ^ op_b;
      AND:     alu_out = rs_data & op_b;
      NOR:     alu_out = ~(rs_data | op_b);
      SLT:     alu_out = {{(DATA_W-1){1'b0}}, slt_bit};
      LUI:     alu_out = {instr.i.imm, {(DATA_W-16){1'b0}}};
      // shifts start from rt
      default: alu_out = rt_data;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result register, doubles as the serial shifter
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (ctrl.start) begin
      result <= alu_out;
    end else if (ctrl.step) begin
      case (ctrl.code)
        SLL, SLLV: result <= {result[DATA_W-2:0], 1'b0};
        SRL, SRLV: result <= {1'b0, result[DATA_W-1:1]};
        SRA, SRAV: result <= {result[DATA_W-1], result[DATA_W-1:1]};
        default:   result <= result;
      endcase
    end
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [exec_pkg::REG_AW-1:0] ra_addr,
  input  logic [exec_pkg::REG_AW-1:0] rb_addr,
  input  logic [exec_pkg::REG_AW-1:0] w_addr,
  input  logic                        w_en,
  input  logic [exec_pkg::DATA_W-1:0] w_data,
  output logic [exec_pkg::DATA_W-1:0] ra_data,
  output logic [exec_pkg::DATA_W-1:0] rb_data
);
  import exec_pkg::*;

  localparam int NUM_REGS = 1 << REG_AW;

  logic [DATA_W-1:0] regs [NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (w_en && (w_addr != '0)) begin
      regs[w_addr] <= w_data;
    end
  end

  // r0 reads as zero
  assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
  assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

//--- logic/shift_timer.sv
`timescale 1ns/1ps

module shift_timer (
  input logic        clk,
  input logic        arst_n,
  exec_ctrl_if.timer ctrl
);
  import exec_pkg::*;

  logic [SHAMT_W-1:0] count;

  // Remaining shift steps
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (ctrl.start) begin
      count <= ctrl.amount;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign ctrl.step = (count != '0);

  // Held off during start so a zero count is not reported too early
  assign ctrl.finished = (count == '0) && !ctrl.start;

  a_start_idle: assert property (
    @(posedge clk) disable iff (!arst_n) ctrl.start |-> (count == '0)
  );

endmodule
